// ==== verilog/cache_geom_pkg.sv ====
package cache_geom_pkg;

    // address split: tag | index | offset
    localparam int tag_w          = 20;
    localparam int index_w        = 6;
    localparam int offset_w       = 6;   // byte offset inside a line

    localparam int words_per_line = 16;
    localparam int num_sets       = 64;  // 2 ways per set

    typedef logic [31:0] word_t;

    // one cache line seen as 16 words, word 0 in the low bits
    typedef word_t [words_per_line-1:0] line_t;

    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [index_w-1:0]  index_t;
    typedef logic [offset_w-1:0] offset_t;

    // word number inside a line, offset[5:2]
    typedef logic [$clog2(words_per_line)-1:0] word_sel_t;

    typedef logic [3:0] strb_t;                      // byte lanes of one word
    typedef logic [words_per_line-1:0] word_wen_t;   // one enable per word

endpackage

// ==== verilog/cache_if_pkg.sv ====
package cache_if_pkg;

    import cache_geom_pkg::*;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } cache_op_e;

    // main controller states
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_lookup  = 3'd1,
        st_select  = 3'd2,  // victim is captured here
        st_miss    = 3'd3,
        st_replace = 3'd4,  // dirty line write-back
        st_hold    = 3'd5,
        st_refill  = 3'd6
    } cache_state_e;

    // request from the pipeline
    typedef struct packed {
        cache_op_e op;
        tag_t      tag;
        index_t    index;
        offset_t   offset;
        strb_t     wstrb;
        word_t     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    // line chosen for eviction, held by the miss buffer
    typedef struct packed {
        logic       way;
        line_meta_t meta;
        line_t      data;
    } victim_t;

endpackage

// ==== verilog/cache_way.sv ====
`timescale 1ns/1ps

module cache_way
    import cache_geom_pkg::*, cache_if_pkg::*;
(
    input  logic       clk,
    input  index_t     idx,
    input  word_wen_t  wen,
    input  line_t      wdata,
    input  logic       meta_we,
    input  line_meta_t meta_in,
    output line_meta_t meta,
    output line_t      data
);

    line_t      lines [num_sets];   // data array
    line_meta_t tags  [num_sets];   // valid, dirty and tag per line

    line_t      line_next;
    line_meta_t meta_next;

    // merge the enabled words into the addressed line
    always_comb begin
        line_next = lines[idx];
        for (int w = 0; w < words_per_line; w++) begin
            if (wen[w]) begin
                line_next[w] = wdata[w];
            end
        end
    end

    assign meta_next = meta_we ? meta_in : tags[idx];

    // data array, registered read
    always_ff @(posedge clk) begin
        if (|wen) begin
            lines[idx] <= line_next;
        end
        data <= line_next;  // write-through, so a lookup right after refill sees new words
    end

    // metadata array, replaced whole
    always_ff @(posedge clk) begin
        if (meta_we) begin
            tags[idx] <= meta_in;
        end
        meta <= meta_next;
    end

endmodule

// ==== verilog/way_select.sv ====
`timescale 1ns/1ps

module way_select
    import cache_geom_pkg::*, cache_if_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       lookup,
    input  tag_t       req_tag,
    input  index_t     req_index,
    input  word_sel_t  word_sel,
    input  line_meta_t meta0,
    input  line_meta_t meta1,
    input  line_t      data0,
    input  line_t      data1,
    output logic       hit,
    output logic       hit_way,
    output word_t      load_word,
    output victim_t    victim
);

    logic hit0;
    logic hit1;
    logic victim_way;

    // one age bit per set, 1 means way 1 goes next
    logic age [num_sets];

    assign hit0 = meta0.valid && (meta0.tag == req_tag);
    assign hit1 = meta1.valid && (meta1.tag == req_tag);

    assign hit     = hit0 | hit1;
    assign hit_way = hit1;

    // word of the hit way, don't care on a miss
    assign load_word = hit1 ? data1[word_sel] : data0[word_sel];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < num_sets; s++) begin
                age[s] <= 1'b0;
            end
        end else if (lookup && hit) begin
            age[req_index] <= ~hit_way;     // the way not used just now is older
        end
    end

    assign victim_way = age[req_index];

    always_comb begin
        victim.way  = victim_way;
        victim.meta = victim_way ? meta1 : meta0;
        victim.data = victim_way ? data1 : data0;
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
    import cache_geom_pkg::*, cache_if_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    // pipeline side
    input  logic        valid,
    input  cpu_req_t    req,
    output logic        ready,
    output logic        data_ok,
    output word_t       rdata,
    // from way_select
    input  logic        hit,
    input  logic        hit_way,
    input  word_t       load_word,
    input  victim_t     victim,
    // to the ways
    output index_t      ram_idx,
    output word_wen_t   wen0,
    output word_wen_t   wen1,
    output logic        meta_we0,
    output logic        meta_we1,
    output line_meta_t  meta_in,
    output line_t       line_wdata,
    // to way_select
    output word_sel_t   word_sel,
    output tag_t        req_tag,
    output index_t      req_index,
    output logic        lookup,
    // bus side
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    input  logic        wr_rdy,
    input  logic        wr_valid
);

    cache_state_e state, state_nxt;
    cpu_req_t     rb;           // request buffer
    victim_t      mb;           // miss buffer
    word_sel_t    beat_cnt;
    logic         clearing;     // valid sweep after reset
    index_t       clr_idx;

    logic         accept;
    logic         store_hit;
    logic         refill_beat;
    logic         victim_dirty;
    word_t        merged;
    word_wen_t    wr_en;
    logic         wr_way;
    logic         wr_meta;

    assign lookup    = (state == st_lookup);
    assign store_hit = lookup && hit && (rb.op == op_store);
    assign ready     = ((state == st_idle) && !clearing) || (lookup && hit && (rb.op == op_load));
    assign accept    = valid && ready;
    assign data_ok   = lookup && hit;
    assign rdata     = load_word;

    assign req_tag   = rb.tag;
    assign req_index = rb.index;
    assign word_sel  = rb.offset[offset_w-1:2];

    assign refill_beat  = (state == st_refill) && ret_valid;
    assign victim_dirty = mb.meta.valid && mb.meta.dirty;

    // incoming index only in the accepting cycle
    assign ram_idx = clearing ? clr_idx : (accept ? req.index : rb.index);

    always_ff @(posedge clk) begin
        if (accept) begin
            rb <= req;
        end
        if (state == st_select) begin
            mb <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            clearing <= 1'b1;
            clr_idx  <= '0;
        end else if (clearing) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == index_t'(num_sets - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (state == st_hold) begin
            beat_cnt <= '0;
        end else if (refill_beat) begin
            beat_cnt <= beat_cnt + 1'b1;    // beats come in word order
        end
    end

    // store bytes laid over the current word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = rb.wstrb[b] ? rb.wdata[8*b +: 8] : load_word[8*b +: 8];
        end
    end

    always_comb begin
        wr_en      = '0;
        wr_way     = mb.way;
        wr_meta    = 1'b0;
        meta_in    = '0;
        line_wdata = {words_per_line{ret_data}};
        if (store_hit) begin
            wr_en      = word_wen_t'(1) << word_sel;
            wr_way     = hit_way;
            wr_meta    = 1'b1;
            meta_in    = '{valid: 1'b1, dirty: 1'b1, tag: rb.tag};
            line_wdata = {words_per_line{merged}};
        end else if (refill_beat) begin
            wr_en   = word_wen_t'(1) << beat_cnt;
            wr_meta = ret_last;
            meta_in = '{valid: 1'b1, dirty: 1'b0, tag: rb.tag};
        end
    end

    assign wen0     = wr_way ? '0 : wr_en;
    assign wen1     = wr_way ? wr_en : '0;
    assign meta_we0 = clearing | (wr_meta & ~wr_way);  // sweep writes zero meta
    assign meta_we1 = clearing | (wr_meta & wr_way);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (accept) state_nxt = st_lookup;
            st_lookup: begin
                if (!hit) begin
                    state_nxt = st_select;
                end else if (accept) begin
                    state_nxt = st_lookup;
                end else begin
                    state_nxt = st_idle;    // store hit always drops back here
                end
            end
            st_select:  state_nxt = st_miss;
            st_miss: begin
                if (!victim_dirty) begin
                    state_nxt = st_hold;
                end else if (wr_rdy) begin
                    state_nxt = st_replace;
                end
            end
            st_replace: if (wr_valid) state_nxt = st_hold;
            st_hold:    if (rd_rdy) state_nxt = st_refill;
            st_refill:  if (ret_valid && ret_last) state_nxt = st_lookup;  // retry hits
            default:    state_nxt = st_idle;
        endcase
    end

    assign rd_req  = ((state == st_hold) && rd_rdy) ||
                     ((state == st_refill) && !(ret_valid && ret_last));
    assign wr_req  = ((state == st_miss) && victim_dirty && wr_rdy) ||
                     ((state == st_replace) && !wr_valid);
    assign rd_addr = {rb.tag, rb.index, offset_t'(0)};
    assign wr_addr = {mb.meta.tag, rb.index, offset_t'(0)};
    assign wr_data = mb.data;

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps

module dcache
    import cache_geom_pkg::*, cache_if_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    // pipeline side
    input  logic        valid,
    input  cpu_req_t    req,
    output logic        ready,
    output logic        data_ok,
    output word_t       rdata,
    // bus read channel
    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    // bus write channel
    output logic        wr_req,
    output logic [31:0] wr_addr,
    output line_t       wr_data,
    input  logic        wr_rdy,
    input  logic        wr_valid
);

    index_t     ram_idx;
    word_wen_t  wen0;
    word_wen_t  wen1;
    logic       meta_we0;
    logic       meta_we1;
    line_meta_t meta_in;
    line_t      line_wdata;
    line_meta_t meta0;
    line_meta_t meta1;
    line_t      data0;
    line_t      data1;
    word_sel_t  word_sel;
    tag_t       req_tag;
    index_t     req_index;
    logic       lookup;
    logic       hit;
    logic       hit_way;
    word_t      load_word;
    victim_t    victim;

    cache_ctrl ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .req        (req),
        .ready      (ready),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .hit        (hit),
        .hit_way    (hit_way),
        .load_word  (load_word),
        .victim     (victim),
        .ram_idx    (ram_idx),
        .wen0       (wen0),
        .wen1       (wen1),
        .meta_we0   (meta_we0),
        .meta_we1   (meta_we1),
        .meta_in    (meta_in),
        .line_wdata (line_wdata),
        .word_sel   (word_sel),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .lookup     (lookup),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .wr_valid   (wr_valid)
    );

    way_select sel (
        .clk       (clk),
        .resetn    (resetn),
        .lookup    (lookup),
        .req_tag   (req_tag),
        .req_index (req_index),
        .word_sel  (word_sel),
        .meta0     (meta0),
        .meta1     (meta1),
        .data0     (data0),
        .data1     (data1),
        .hit       (hit),
        .hit_way   (hit_way),
        .load_word (load_word),
        .victim    (victim)
    );

    // both ways share index and write data, enables are per way
    cache_way way0 (
        .clk     (clk),
        .idx     (ram_idx),
        .wen     (wen0),
        .wdata   (line_wdata),
        .meta_we (meta_we0),
        .meta_in (meta_in),
        .meta    (meta0),
        .data    (data0)
    );

    cache_way way1 (
        .clk     (clk),
        .idx     (ram_idx),
        .wen     (wen1),
        .wdata   (line_wdata),
        .meta_we (meta_we1),
        .meta_in (meta_in),
        .meta    (meta1),
        .data    (data1)
    );

endmodule

// ==== bench/dcache_chk.sv ====
`timescale 1ns/1ps

module dcache_chk
    import cache_geom_pkg::*, cache_if_pkg::*;
(
    input logic     clk,
    input logic     resetn,
    input logic     valid,
    input cpu_req_t req,
    input logic     ready,
    input logic     data_ok,
    input logic     rd_req,
    input logic     ret_valid,
    input logic     ret_last,
    input logic     wr_req,
    input logic     wr_valid
);

    int unsigned fail_cnt = 0;  // failed assertions so far
    cache_op_e   last_op;       // op of the request accepted last

    always_ff @(posedge clk) begin
        if (!resetn) begin
            last_op <= op_load;
        end else if (valid && ready) begin
            last_op <= req.op;
        end
    end

    bus_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
    else begin
        fail_cnt++;
        $error("rd_req and wr_req high together");
    end

    // read request only ends on the last beat
    rd_held: assert property (@(posedge clk) disable iff (!resetn)
        $fell(rd_req) |-> ret_valid && ret_last)
    else begin
        fail_cnt++;
        $error("rd_req dropped before ret_last");
    end

    wr_held: assert property (@(posedge clk) disable iff (!resetn)
        $fell(wr_req) |-> wr_valid)
    else begin
        fail_cnt++;
        $error("wr_req dropped before wr_valid");
    end

    store_single: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && last_op == op_store |=> !data_ok)
    else begin
        fail_cnt++;
        $error("data_ok held for two cycles after a store");
    end

endmodule

bind dcache dcache_chk chk (
    .clk       (clk),
    .resetn    (resetn),
    .valid     (valid),
    .req       (req),
    .ready     (ready),
    .data_ok   (data_ok),
    .rd_req    (rd_req),
    .ret_valid (ret_valid),
    .ret_last  (ret_last),
    .wr_req    (wr_req),
    .wr_valid  (wr_valid)
);

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import cache_geom_pkg::*, cache_if_pkg::*;
();

    localparam int n_req      = 313;                  // requests over all tests
    localparam int max_cycles = 4 + 70 + 200 * n_req;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        ready;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy;
    logic        wr_valid;

    word_t       bus_mem [logic [31:0]];   // what the bus holds, keyed by word address
    word_t       shadow  [logic [31:0]];   // what the CPU should see
    word_t       exp_q   [$];
    cache_op_e   op_q    [$];
    int unsigned acc_q   [$];
    word_t       exp_word;
    cache_op_e   exp_op;

    int unsigned cycle = 0;
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned err_mark = 0;
    int unsigned tests_run = 0;
    int unsigned tests_failed = 0;
    int unsigned last_lat;
    int unsigned acc_cycle;
    int unsigned rd_count = 0;
    int unsigned wr_count = 0;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    line_t       last_wr_data;

    dcache uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin : watchdog
        wait (cycle >= max_cycles);
        $display("run stopped at cycle %0d, a request never completed", cycle);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // untouched memory, every address bit matters
    function automatic word_t fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t exp_load(input logic [31:0] a);
        logic [31:0] k;
        k = {a[31:2], 2'b00};
        return shadow.exists(k) ? shadow[k] : fill_word(k);
    endfunction

    function automatic line_t shadow_line(input logic [31:0] base);
        line_t l;
        for (int w = 0; w < words_per_line; w++) begin
            l[w] = exp_load(base + 32'(4 * w));
        end
        return l;
    endfunction

    task automatic shadow_store(input logic [31:0] a, input strb_t s, input word_t d);
        word_t w;
        w = exp_load(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) w[8*b +: 8] = d[8*b +: 8];  // byte lanes by strobe
        end
        shadow[{a[31:2], 2'b00}] = w;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    function automatic int unsigned err_total();
        return errors + uut.chk.fail_cnt;
    endfunction

    // holds req until accepted, queues the expected result
    task automatic issue(input cache_op_e op, input logic [31:0] a, input strb_t s,
                         input word_t d);
        req   = '{op: op, tag: a[31:12], index: a[11:6], offset: a[5:0], wstrb: s, wdata: d};
        valid = 1'b1;
        @(negedge clk);
        while (!ready) @(negedge clk);
        acc_cycle = cycle;
        acc_q.push_back(cycle);
        op_q.push_back(op);
        if (op == op_store) shadow_store(a, s, d);
        exp_q.push_back(exp_load(a));
        step();
        valid = 1'b0;
    endtask

    task automatic drain();
        while (op_q.size() != 0) @(negedge clk);
        step();
    endtask

    task automatic finish_test(input string name);
        drain();
        tests_run++;
        if (err_total() == err_mark) begin
            $display("%-26s ok", name);
        end else begin
            tests_failed++;
            $display("%-26s failed, %0d errors", name, err_total() - err_mark);
        end
        err_mark = err_total();
    endtask

    // every data_ok retires the oldest request
    always @(negedge clk) begin
        if (resetn && data_ok) begin
            if (op_q.size() == 0) begin
                report_fault("data_ok came with no request outstanding");
            end else begin
                last_lat = cycle - acc_q.pop_front();
                exp_op   = op_q.pop_front();
                exp_word = exp_q.pop_front();
                if (exp_op == op_load) check_word("rdata", rdata, exp_word);
            end
        end
    end

    initial begin : read_server
        logic [31:0] base;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wait (resetn);
        forever begin
            repeat ($urandom_range(3, 0)) step();
            rd_rdy = 1'b1;
            @(negedge clk);
            while (!rd_req) @(negedge clk);
            base         = rd_addr;
            last_rd_addr = rd_addr;
            rd_count++;
            step();
            rd_rdy = 1'b0;
            for (int i = 0; i < words_per_line; i++) begin
                repeat ($urandom_range(3, 0)) step();
                ret_valid = 1'b1;
                ret_last  = (i == words_per_line - 1);
                ret_data  = bus_mem.exists(base + 32'(4 * i)) ? bus_mem[base + 32'(4 * i)]
                                                            : fill_word(base + 32'(4 * i));
                step();
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial begin : write_server
        wr_rdy   = 1'b0;
        wr_valid = 1'b0;
        wait (resetn);
        forever begin
            repeat ($urandom_range(3, 0)) step();
            wr_rdy = 1'b1;
            @(negedge clk);
            while (!wr_req) @(negedge clk);
            last_wr_addr = wr_addr;
            last_wr_data = wr_data;
            wr_count++;
            for (int w = 0; w < words_per_line; w++) begin
                bus_mem[wr_addr + 32'(4 * w)] = wr_data[w];
            end
            step();
            wr_rdy = 1'b0;
            repeat ($urandom_range(3, 0)) step();
            wr_valid = 1'b1;     // one-cycle completion pulse
            step();
            wr_valid = 1'b0;
        end
    end

    initial begin : main
        logic [31:0] a;
        int unsigned r0;
        int unsigned acc [4];
        void'($urandom(71820));
        valid  = 1'b0;
        req    = '0;
        resetn = 1'b0;
        repeat (4) step();
        resetn = 1'b1;
        repeat (70) step();     // valid bits cleared by the sweep

        r0 = rd_count;
        issue(op_load, 32'h0000_1048, '0, '0);
        drain();
        check_addr("rd_addr", last_rd_addr, 32'h0000_1040);
        if (rd_count != r0 + 1) report_fault("load after reset did not fetch its line");
        finish_test("load miss after reset");

        r0 = rd_count;
        issue(op_load, 32'h0000_107c, '0, '0);
        drain();
        if (rd_count != r0) report_fault("load to a cached line went to the bus");
        if (last_lat != 1) report_fault($sformatf("hit answered after %0d cycles", last_lat));
        finish_test("load hit latency");

        issue(op_store, 32'h0000_1048, 4'b0101, 32'haabb_ccdd);
        issue(op_load, 32'h0000_1048, '0, '0);
        finish_test("partial store then load");

        // A, B and C share set 5
        issue(op_load, 32'h0010_0148, '0, '0);
        issue(op_load, 32'h0020_0144, '0, '0);
        issue(op_store, 32'h0010_0150, 4'hf, 32'h1234_5678);
        issue(op_load, 32'h0020_0140, '0, '0);
        drain();
        r0 = wr_count;
        issue(op_load, 32'h0030_0140, '0, '0);
        drain();
        if (wr_count != r0 + 1) report_fault("dirty line A was not written back");
        check_addr("wr_addr", last_wr_addr, 32'h0010_0140);
        check_line("wr_data", last_wr_data, shadow_line(32'h0010_0140));
        finish_test("eviction by age");

        for (int i = 0; i < 4; i++) begin
            issue(op_load, 32'h0000_1040 + 32'(8 * i), '0, '0);
            acc[i] = acc_cycle;
        end
        drain();
        for (int i = 1; i < 4; i++) begin
            if (acc[i] != acc[i-1] + 1) report_fault("back-to-back load hits were not accepted");
        end
        finish_test("back-to-back hits");

        for (int n = 0; n < 300; n++) begin
            a = {20'h0a000 + 20'(20'h00137 * $urandom_range(5, 0)),
                 6'(8 + $urandom_range(3, 0)), 4'($urandom_range(15, 0)), 2'b00};
            if ($urandom_range(1, 0) == 1) begin
                issue(op_store, a, 4'($urandom_range(15, 1)), $urandom());
            end else begin
                issue(op_load, a, '0, '0);
            end
        end
        finish_test("random loads and stores");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, err_total());
        if (err_total() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/cache_geom_pkg.sv
verilog/cache_if_pkg.sv
verilog/cache_way.sv
verilog/way_select.sv
verilog/cache_ctrl.sv
verilog/dcache.sv
bench/dcache_chk.sv
bench/dcache_tb.sv
